//--- source/cp0_settings.svh
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Coprocessor register numbers
////////////////////////////////////////////////////////////
`define CP0_REG_SR      5'd12
`define CP0_REG_CAUSE   5'd13
`define CP0_REG_EPC     5'd14
`define CP0_REG_PRID    5'd15

// Processor id word seen after reset
`define CP0_PRID_VALUE  32'h0000_3A01

////////////////////////////////////////////////////////////
// Instruction encodings
////////////////////////////////////////////////////////////
`define CP0_OP_COP0     6'b010000
`define CP0_RS_MF       5'b00000
`define CP0_RS_MT       5'b00100
// CO bit set in rs for eret
`define CP0_RS_CO       5'b10000
`define CP0_FUNCT_ERET  6'b011000

// Writable Status bits, IM at 15:10 plus EXL and IE
`define CP0_SR_WMASK    32'h0000_FC03

`endif

//--- source/cp0Pkg.sv
package cp0Pkg;

	////////////////////////////////////////////////////////////
	// Pipeline side types
	////////////////////////////////////////////////////////////

	// R-format view of an instruction word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrFields;

	// Per-stage PC info, zero PC means an empty stage
	typedef struct packed {
		logic [31:0] backPc;
		logic        afterJump;
	} stageInfo;

	// Exception code, zero is no exception
	typedef logic [4:0] excCode;

	////////////////////////////////////////////////////////////
	// Register layouts
	////////////////////////////////////////////////////////////

	// Status word
	typedef struct packed {
		logic [15:0] zeroHi;
		logic [5:0]  im;
		logic [7:0]  zeroMid;
		logic        exl;
		logic        ie;
	} statusFields;

	// Cause word
	typedef struct packed {
		logic        bd;
		logic [14:0] zeroHi;
		logic [5:0]  ip;
		logic [2:0]  zeroMid;
		excCode      code;
		logic [1:0]  zeroLo;
	} causeFields;

	// One register word, read raw or as Status or Cause
	typedef union packed {
		logic [31:0] raw;
		statusFields status;
		causeFields  cause;
	} cp0Word;

endpackage

//--- source/cop0Decode.sv
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cop0Decode (
	input  cp0Pkg::instrFields instr,
	output logic               mtc0,
	output logic               mfc0,
	output logic               eret,
	output logic [4:0]         regIdx
);

	logic isCop0;

	// Opcode match shared by all three forms
	assign isCop0 = (instr.opcode == `CP0_OP_COP0);

	// Moves are told apart by rs
	assign mtc0 = isCop0 && (instr.rs == `CP0_RS_MT);
	assign mfc0 = isCop0 && (instr.rs == `CP0_RS_MF);

	// eret needs the CO bit and its funct
	assign eret = isCop0 && (instr.rs == `CP0_RS_CO) &&
		(instr.funct == `CP0_FUNCT_ERET);

	// Coprocessor register sits in rd
	assign regIdx = instr.rd;

endmodule

//--- source/victimSelect.sv
`timescale 1ns/1ps

module victimSelect (
	input  cp0Pkg::stageInfo stageD,
	input  cp0Pkg::stageInfo stageE,
	input  cp0Pkg::stageInfo stageM,
	output logic [31:0]      macroPc,
	output logic [31:0]      victimPc,
	output logic             victimBd
);

	import cp0Pkg::*;

	stageInfo victim;

	// Oldest non-empty stage wins, M then E then D
	always_comb begin
		if (stageM.backPc != '0) begin
			victim = stageM;
		end else if (stageE.backPc != '0) begin
			victim = stageE;
		end else if (stageD.backPc != '0) begin
			victim = stageD;
		end else begin
			victim = '0;
		end
	end

	assign macroPc = victim.backPc;

	// In a delay slot, return to the jump itself
	assign victimBd = victim.afterJump;
	assign victimPc = victim.afterJump ? (victim.backPc - 32'd4) : victim.backPc;

endmodule

//--- source/cp0Regs.sv
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0Regs (
	input  logic             clk,
	input  logic             reset,
	input  logic             mtc0,
	input  logic             mfc0,
	input  logic             eret,
	input  logic [4:0]       regIdx,
	input  logic [31:0]      writeData,
	input  logic [5:0]       hwInt,
	input  cp0Pkg::excCode   excCodeIn,
	input  logic [31:0]      victimPc,
	input  logic             victimBd,
	output cp0Pkg::cp0Word   readData,
	output logic [29:0]      epc,
	output logic             excReq
);

	import cp0Pkg::*;

	// Register file
	cp0Word statusReg;
	cp0Word causeReg;
	cp0Word epcReg;
	cp0Word pridReg;

	logic   intReq;
	logic   excSet;
	excCode nextCode;

	////////////////////////////////////////////////////////////
	// Request logic
	////////////////////////////////////////////////////////////

	// Unmasked line, global enable on, not already in a handler
	assign intReq = (|(hwInt & statusReg.status.im)) &&
		statusReg.status.ie && !statusReg.status.exl;

	// Pipeline raised a fault
	assign excSet = (excCodeIn != '0);

	assign excReq = intReq || excSet;

	// Interrupt takes precedence, and reports code 0
	assign nextCode = intReq ? '0 : excCodeIn;

	////////////////////////////////////////////////////////////
	// Register updates
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			statusReg   <= '0;
			causeReg    <= '0;
			epcReg      <= '0;
			pridReg.raw <= `CP0_PRID_VALUE;
		end else begin
			// Pending lines track hwInt one cycle late
			causeReg.cause.ip <= hwInt;

			if (mtc0) begin
				// Status keeps only IM, EXL and IE
				if (regIdx == `CP0_REG_SR) begin
					statusReg.raw <= writeData & `CP0_SR_WMASK;
				end else if (regIdx == `CP0_REG_EPC) begin
					epcReg.raw <= writeData;
				end
				// Cause and PRId are read-only here
			end else if (eret) begin
				// Leave the handler
				statusReg.status.exl <= 1'b0;
			end else if (excReq) begin
				// Enter the handler
				statusReg.status.exl <= 1'b1;
				causeReg.cause.code  <= nextCode;
				causeReg.cause.bd    <= victimBd;
				// Return address forced to a word boundary
				epcReg.raw           <= {victimPc[31:2], 2'b00};
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////

	// mfc0 read mux, zero when idle or unknown index
	always_comb begin
		readData = '0;
		if (mfc0) begin
			case (regIdx)
				`CP0_REG_SR:    readData = statusReg;
				`CP0_REG_CAUSE: readData = causeReg;
				`CP0_REG_EPC:   readData = epcReg;
				`CP0_REG_PRID:  readData = pridReg;
				default:        readData = '0;
			endcase
		end
	end

	// Handler return target, word address
	assign epc = epcReg.raw[31:2];

endmodule

//--- source/cp0Unit.sv
`timescale 1ns/1ps

module cp0Unit (
	input  logic               clk,
	input  logic               reset,
	input  cp0Pkg::instrFields instrM,
	input  cp0Pkg::instrFields instrW,
	input  logic [31:0]        writeData,
	input  logic [5:0]         hwInt,
	input  cp0Pkg::excCode     excCodeIn,
	input  cp0Pkg::stageInfo   stageD,
	input  cp0Pkg::stageInfo   stageE,
	input  cp0Pkg::stageInfo   stageM,
	output cp0Pkg::cp0Word     readData,
	output logic [29:0]        epc,
	output logic               excReq,
	output logic [31:0]        macroPc
);

	// Decoded controls
	logic        mtc0;
	logic        mfc0;
	logic        eret;
	logic [4:0]  regIdx;

	// Exception target
	logic [31:0] victimPc;
	logic        victimBd;

	// Moves are resolved in M
	cop0Decode i_decM (
		.instr  (instrM),
		.mtc0   (mtc0),
		.mfc0   (mfc0),
		.eret   (),
		.regIdx (regIdx)
	);

	// eret takes effect from W
	cop0Decode i_decW (
		.instr  (instrW),
		.mtc0   (),
		.mfc0   (),
		.eret   (eret),
		.regIdx ()
	);

	victimSelect i_victim (
		.stageD   (stageD),
		.stageE   (stageE),
		.stageM   (stageM),
		.macroPc  (macroPc),
		.victimPc (victimPc),
		.victimBd (victimBd)
	);

	cp0Regs i_regs (
		.clk       (clk),
		.reset     (reset),
		.mtc0      (mtc0),
		.mfc0      (mfc0),
		.eret      (eret),
		.regIdx    (regIdx),
		.writeData (writeData),
		.hwInt     (hwInt),
		.excCodeIn (excCodeIn),
		.victimPc  (victimPc),
		.victimBd  (victimBd),
		.readData  (readData),
		.epc       (epc),
		.excReq    (excReq)
	);

endmodule

//--- dv/cp0Tb_assert.sv
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0Tb_assert (
	input logic           clk,
	input logic           reset,
	input logic           mtc0,
	input logic           eret,
	input logic           excReq,
	input cp0Pkg::excCode excCodeIn,
	input cp0Pkg::cp0Word statusReg,
	input cp0Pkg::cp0Word epcReg
);

	// Only IM, EXL and IE may ever be set
	statusZeros: assert property (@(posedge clk) disable iff (reset)
		(statusReg.raw & ~`CP0_SR_WMASK) == 32'd0)
		else $error("Status has bits set outside IM, EXL and IE");

	// No interrupt while inside a handler
	noNestedIrq: assert property (@(posedge clk) disable iff (reset)
		(statusReg.status.exl && excCodeIn == '0) |-> !excReq)
		else $error("excReq raised with EXL set and no fault code");

	// Exception entry leaves a word address
	epcAligned: assert property (@(posedge clk) disable iff (reset)
		(excReq && !mtc0 && !eret) |=> (epcReg.raw[1:0] == 2'b00))
		else $error("EPC not word aligned after exception entry");

	eretClears: assert property (@(posedge clk) disable iff (reset)
		(eret && !mtc0) |=> !statusReg.status.exl)
		else $error("EXL still set one cycle after eret");

endmodule

bind cp0Regs cp0Tb_assert i_assert (
	.clk       (clk),
	.reset     (reset),
	.mtc0      (mtc0),
	.eret      (eret),
	.excReq    (excReq),
	.excCodeIn (excCodeIn),
	.statusReg (statusReg),
	.epcReg    (epcReg)
);

//--- dv/cp0Tb.sv
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0Tb;

	import cp0Pkg::*;

	// Expected outputs and next register state for one cycle
	typedef struct packed {
		cp0Word      nextStatus;
		cp0Word      nextCause;
		cp0Word      nextEpc;
		logic        excReq;
		cp0Word      readData;
		logic [31:0] macroPc;
	} refResult;

	logic       clk;
	logic       reset;
	instrFields instrM;
	instrFields instrW;
	logic [31:0] writeData;
	logic [5:0] hwInt;
	excCode     excCodeIn;
	stageInfo   stageD;
	stageInfo   stageE;
	stageInfo   stageM;
	cp0Word     readData;
	logic [29:0] epc;
	logic       excReq;
	logic [31:0] macroPc;

	// Model state
	cp0Word mStatus;
	cp0Word mCause;
	cp0Word mEpc;

	int     checks;
	int     mismatches;
	int     timeouts;
	integer seed;

	cp0Unit i_dut (
		.clk       (clk),
		.reset     (reset),
		.instrM    (instrM),
		.instrW    (instrW),
		.writeData (writeData),
		.hwInt     (hwInt),
		.excCodeIn (excCodeIn),
		.stageD    (stageD),
		.stageE    (stageE),
		.stageM    (stageM),
		.readData  (readData),
		.epc       (epc),
		.excReq    (excReq),
		.macroPc   (macroPc)
	);

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic refResult refModel(input cp0Word st, input cp0Word ca, input cp0Word ep,
		input instrFields iM, input instrFields iW, input logic [31:0] wData,
		input logic [5:0] irq, input excCode code, input stageInfo sD, input stageInfo sE,
		input stageInfo sM);
		refResult r;
		stageInfo oldest;
		logic isMt;
		logic isMf;
		logic isEret;
		logic irqTaken;
		logic [31:0] retPc;
		r = '0;
		r.nextStatus = st;
		r.nextCause = ca;
		r.nextEpc = ep;
		isMt = (iM.opcode == `CP0_OP_COP0) && (iM.rs == `CP0_RS_MT);
		isMf = (iM.opcode == `CP0_OP_COP0) && (iM.rs == `CP0_RS_MF);
		isEret = (iW.opcode == `CP0_OP_COP0) && (iW.rs == `CP0_RS_CO) &&
			(iW.funct == `CP0_FUNCT_ERET);
		// Interrupt needs a masked line, IE on, EXL off
		irqTaken = ((irq & st.status.im) != 6'd0) && st.status.ie && !st.status.exl;
		r.excReq = irqTaken || (code != 5'd0);
		// Oldest valid stage from M to E to D
		if (sM.backPc != 32'd0) oldest = sM;
		else if (sE.backPc != 32'd0) oldest = sE;
		else if (sD.backPc != 32'd0) oldest = sD;
		else oldest = '0;
		r.macroPc = oldest.backPc;
		if (isMf) begin
			case (iM.rd)
				5'd12: r.readData = st;
				5'd13: r.readData = ca;
				5'd14: r.readData = ep;
				5'd15: r.readData.raw = `CP0_PRID_VALUE;
				default: r.readData = '0;
			endcase
		end
		// Pending lines are hwInt a cycle late
		r.nextCause.cause.ip = irq;
		if (isMt) begin
			if (iM.rd == 5'd12) r.nextStatus.raw = wData & 32'h0000_FC03;
			else if (iM.rd == 5'd14) r.nextEpc.raw = wData;
		end else if (isEret) begin
			r.nextStatus.status.exl = 1'b0;
		end else if (r.excReq) begin
			retPc = oldest.afterJump ? oldest.backPc - 32'd4 : oldest.backPc;
			r.nextStatus.status.exl = 1'b1;
			r.nextCause.cause.code = irqTaken ? 5'd0 : code;
			r.nextCause.cause.bd = oldest.afterJump;
			r.nextEpc.raw = retPc & 32'hFFFF_FFFC;
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkWord(input string name, input cp0Word got, input cp0Word exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic checkEpc(input string name, input logic [29:0] got, input logic [29:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic checkPc(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic instrFields moveInstr(input logic [4:0] rs, input logic [4:0] rd);
		instrFields f;
		f = '0;
		f.opcode = `CP0_OP_COP0;
		f.rs = rs;
		f.rt = 5'd8;
		f.rd = rd;
		return f;
	endfunction

	function automatic instrFields eretInstr();
		instrFields f;
		f = '0;
		f.opcode = `CP0_OP_COP0;
		f.rs = `CP0_RS_CO;
		f.funct = `CP0_FUNCT_ERET;
		return f;
	endfunction

	// One cycle of pipeline inputs on the falling edge
	task automatic step(input instrFields iM, input instrFields iW, input logic [31:0] wd,
		input logic [5:0] irq, input excCode code);
		@(negedge clk);
		instrM = iM;
		instrW = iW;
		writeData = wd;
		hwInt = irq;
		excCodeIn = code;
	endtask

	// Called right after step in the same falling edge time step
	task automatic setStages(input logic [31:0] pcD, input logic [31:0] pcE,
		input logic [31:0] pcM, input logic [2:0] jumps);
		stageD = {pcD, jumps[0]};
		stageE = {pcE, jumps[1]};
		stageM = {pcM, jumps[2]};
	endtask

	task automatic waitForExcReq(input int limit);
		int n;
		n = 0;
		#1;
		while (!excReq && n < limit) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!excReq) begin
			$display("Timeout at %0t: excReq did not rise within %0d cycles", $time, limit);
			timeouts++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Compare before each rising edge, then advance the model
	initial begin
		refResult exp;
		forever begin
			@(negedge clk);
			#1;
			if (reset) begin
				mStatus = '0;
				mCause = '0;
				mEpc = '0;
			end else begin
				exp = refModel(mStatus, mCause, mEpc, instrM, instrW, writeData, hwInt,
					excCodeIn, stageD, stageE, stageM);
				checkWord("readData", readData, exp.readData);
				checkBit("excReq", excReq, exp.excReq);
				checkEpc("epc", epc, mEpc.raw[31:2]);
				checkPc("macroPc", macroPc, exp.macroPc);
				checks++;
				mStatus = exp.nextStatus;
				mCause = exp.nextCause;
				mEpc = exp.nextEpc;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int i;
		logic [31:0] r;
		logic [31:0] pcBase;
		instrFields iM;
		seed = 56;
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		reset = 1'b1;
		instrM = '0;
		instrW = '0;
		writeData = '0;
		hwInt = '0;
		excCodeIn = '0;
		stageD = '0;
		stageE = '0;
		stageM = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Reset values, PRId and an unknown index
		for (i = 12; i <= 16; i++) step(moveInstr(`CP0_RS_MF, i[4:0]), '0, '0, '0, '0);

		// Status masking, EPC write, Cause ignored
		step(moveInstr(`CP0_RS_MT, `CP0_REG_SR), '0, 32'hFFFF_FFFF, '0, '0);
		step(moveInstr(`CP0_RS_MF, `CP0_REG_SR), '0, '0, '0, '0);
		step(moveInstr(`CP0_RS_MT, `CP0_REG_EPC), '0, 32'h1234_5678, '0, '0);
		step(moveInstr(`CP0_RS_MT, `CP0_REG_CAUSE), '0, 32'hFFFF_FFFF, '0, '0);
		step(moveInstr(`CP0_RS_MF, `CP0_REG_CAUSE), '0, '0, '0, '0);
		step(moveInstr(`CP0_RS_MT, `CP0_REG_SR), '0, 32'h0000_0401, '0, '0);

		// Masked interrupt with M empty so E is the victim
		step('0, '0, '0, 6'b000001, '0);
		setStages(32'h0000_1004, 32'h0000_1000, 32'h0, 3'b000);
		waitForExcReq(4);
		step(moveInstr(`CP0_RS_MF, `CP0_REG_CAUSE), '0, '0, '0, '0);
		step(moveInstr(`CP0_RS_MF, `CP0_REG_SR), '0, '0, '0, '0);

		// Fault in a delay slot, then a blocked interrupt
		step('0, '0, '0, '0, 5'd10);
		setStages(32'h0000_2010, 32'h0000_200C, 32'h0000_2008, 3'b100);
		step(moveInstr(`CP0_RS_MF, `CP0_REG_CAUSE), '0, '0, 6'b000001, '0);

		// eret, then mtc0 beats eret and a fault
		step('0, eretInstr(), '0, '0, '0);
		step(moveInstr(`CP0_RS_MT, `CP0_REG_SR), eretInstr(), 32'h0000_0403, '0, 5'd4);
		step(moveInstr(`CP0_RS_MF, `CP0_REG_SR), '0, '0, '0, '0);
		step(moveInstr(`CP0_RS_MF, `CP0_REG_CAUSE), '0, '0, '0, '0);

		// Random mixed traffic
		for (i = 0; i < 300; i++) begin
			r = $random(seed);
			if (r[2:0] < 3'd2) iM = moveInstr(`CP0_RS_MT, 5'd11 + r[5:3]);
			else if (r[2:0] < 3'd5) iM = moveInstr(`CP0_RS_MF, 5'd11 + r[5:3]);
			else iM = '0;
			step(iM, (r[8:6] == 3'd0) ? eretInstr() : '0, $random(seed), r[23:18],
				(r[12:9] == 4'd0) ? r[17:13] : 5'd0);
			pcBase = $random(seed) & 32'h00FF_FFF0;
			setStages(r[24] ? 32'h0 : pcBase, r[25] ? 32'h0 : pcBase + 4,
				r[26] ? 32'h0 : pcBase + 8, r[29:27]);
		end

		step('0, '0, '0, '0, '0);
		@(posedge clk);
		$display("Checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+source
source/cp0Pkg.sv
source/cop0Decode.sv
source/victimSelect.sv
source/cp0Regs.sv
source/cp0Unit.sv
dv/cp0Tb_assert.sv
dv/cp0Tb.sv
